// ==== files.f ====
+incdir+include
design/l0_icache_pkg.sv
design/l0_lookup_if.sv
design/l0_evict_if.sv
design/l0_line_store.sv
design/l0_branch_predecode.sv
design/l0_refill_ctrl.sv
design/l0_icache.sv
dv/l0_icache_tb_mem.sv
dv/l0_icache_tb.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := l0_icache_tb
RTL_TOP    := l0_icache
FILELIST   := files.f
BUILD_DIR  := obj_dir
LINT_FLAGS := --lint-only --timing
SIM_FLAGS  := --binary --timing -j 0
PASS_MSG   := *** PASSED ***

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(BUILD_DIR)

// ==== dv/l0_icache_tb.sv ====
/*
 * L0 instruction cache testbench
 * Directed tests for refill, flush, round-robin eviction, next-line and
 * branch prefetch, and request back-pressure
 */

`timescale 1ns/1ns

`include "l0_cfg.svh"

module l0_icache_tb import l0_icache_pkg::*; ();

  localparam int RESET_CYCLES = 8;
  localparam int WAIT_LIMIT   = 40;
  // About two bounded waits per fetch over all tests
  localparam int NUM_WAITS    = 40;
  localparam int MAX_CYCLES   = RESET_CYCLES + NUM_WAITS * WAIT_LIMIT + 100;
  localparam int SEED         = 32'h4b6e;

  localparam addr_t BEQ_ADDR = 32'h0000_1208;
  localparam addr_t JAL_ADDR = 32'h0000_2304;
  // beq x0, x0, -64
  localparam word_t BEQ_WORD = {1'b1, 6'b111110, 5'd0, 5'd0, 3'b000, 4'b0000, 1'b1, 7'b1100011};
  // jal x0, +256
  localparam word_t JAL_WORD = {1'b0, 10'b0010000000, 1'b0, 8'd0, 5'd0, 7'b1101111};

  logic  clk_i;
  logic  rst_ni;
  logic  flush_i;
  logic  enable_prefetch_i;
  logic  in_valid_i;
  addr_t in_addr_i;
  word_t in_data_o;
  logic  in_ready_o;
  addr_t out_req_addr_o;
  logic  out_req_valid_o;
  logic  out_req_is_prefetch_o;
  logic  out_req_ready_i;
  logic  out_rsp_valid_i;
  line_t out_rsp_data_i;
  logic  evt_hit_o;
  logic  evt_miss_o;
  logic  evt_prefetch_o;
  logic  mem_hold;
  logic  mem_busy;
  int    mem_overlaps;

  int check_count;
  int check_errors;
  int other_errors;
  int cycle_cnt;

  l0_icache dut (.*);

  l0_icache_tb_mem #(
    .SEED     (SEED),
    .BEQ_ADDR (BEQ_ADDR),
    .BEQ_WORD (BEQ_WORD),
    .JAL_ADDR (JAL_ADDR),
    .JAL_WORD (JAL_WORD)
  ) mem (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .hold_i      (mem_hold),
    .req_valid_i (out_req_valid_o),
    .req_addr_i  (out_req_addr_o),
    .req_ready_o (out_req_ready_i),
    .rsp_valid_o (out_rsp_valid_i),
    .rsp_data_o  (out_rsp_data_i),
    .busy_o      (mem_busy),
    .overlaps_o  (mem_overlaps)
  );

  always #50 clk_i = ~clk_i;

  // --------------------------------------------------------------------------
  // Reference model and helpers
  // --------------------------------------------------------------------------
  function automatic word_t expected_word(input addr_t a);
    word_t w;
    w = {a[31:7] ^ a[24:0], 7'b0010011};
    if (a == BEQ_ADDR) begin
      w = BEQ_WORD;
    end else if (a == JAL_ADDR) begin
      w = JAL_WORD;
    end
    return w;
  endfunction

  function automatic addr_t line_of(input addr_t a);
    return {a[31:`L0_LINE_ALIGN], {`L0_LINE_ALIGN{1'b0}}};
  endfunction

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    check_count++;
    if (got !== exp) begin
      check_errors++;
      $display("CHECK FAILED %s: got 0x%08h, expected 0x%08h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic start_fetch(input addr_t a);
    @(posedge clk_i);
    in_valid_i <= 1'b1;
    in_addr_i  <= a;
    @(negedge clk_i);
  endtask

  task automatic end_fetch();
    @(posedge clk_i);
    in_valid_i <= 1'b0;
  endtask

  task automatic wait_ready();
    int n;
    n = 0;
    while (!in_ready_o && n < WAIT_LIMIT) begin
      @(negedge clk_i);
      n++;
    end
    if (!in_ready_o) begin
      other_errors++;
      $display("No hit for address 0x%08h within %0d cycles", in_addr_i, WAIT_LIMIT);
    end
  endtask

  // Stops in the cycle of the refill strobe
  task automatic wait_response();
    int n;
    n = 0;
    while (!out_rsp_valid_i && n < WAIT_LIMIT) begin
      @(negedge clk_i);
      n++;
    end
    if (!out_rsp_valid_i) begin
      other_errors++;
      $display("No refill response within %0d cycles", WAIT_LIMIT);
    end
  endtask

  // Let any outstanding refill or prefetch finish
  task automatic drain();
    int n;
    n = 0;
    @(negedge clk_i);
    while ((out_req_valid_o || mem_busy) && n < WAIT_LIMIT) begin
      @(negedge clk_i);
      n++;
    end
    if (out_req_valid_o || mem_busy) begin
      other_errors++;
      $display("Request port still busy after %0d cycles", WAIT_LIMIT);
    end
  endtask

  task automatic fetch_line(input addr_t a);
    start_fetch(a);
    wait_ready();
    check("in_data_o", in_data_o, expected_word(a));
    end_fetch();
    drain();
  endtask

  task automatic prefetch_after_hit(input addr_t a, input addr_t exp_req);
    start_fetch(a);
    wait_ready();
    check("in_data_o", in_data_o, expected_word(a));
    check("evt_prefetch_o", 32'(evt_prefetch_o), 1);
    end_fetch();
    @(negedge clk_i);
    check("out_req_valid_o", 32'(out_req_valid_o), 1);
    check("out_req_is_prefetch_o", 32'(out_req_is_prefetch_o), 1);
    check("out_req_addr_o", out_req_addr_o, exp_req);
    drain();
  endtask

  // --------------------------------------------------------------------------
  // Directed tests
  // --------------------------------------------------------------------------
  task automatic miss_then_hit();
    $display("Test: miss, refill and hit");
    start_fetch(32'h0000_0424);
    check("in_ready_o", 32'(in_ready_o), 0);
    check("out_req_valid_o", 32'(out_req_valid_o), 1);
    check("out_req_is_prefetch_o", 32'(out_req_is_prefetch_o), 0);
    check("out_req_addr_o", out_req_addr_o, 32'h0000_0420);
    check("evt_miss_o", 32'(evt_miss_o), 1);
    wait_response();
    check("in_ready_o", 32'(in_ready_o), 0);
    // Line becomes valid one cycle after the strobe
    @(negedge clk_i);
    check("in_ready_o", 32'(in_ready_o), 1);
    check("in_data_o", in_data_o, expected_word(32'h0000_0424));
    check("evt_hit_o", 32'(evt_hit_o), 1);
    end_fetch();
    drain();
  endtask

  task automatic flush_invalidates();
    $display("Test: flush");
    start_fetch(32'h0000_0424);
    check("in_ready_o", 32'(in_ready_o), 1);
    end_fetch();
    @(posedge clk_i);
    flush_i <= 1'b1;
    @(posedge clk_i);
    flush_i <= 1'b0;
    start_fetch(32'h0000_0424);
    check("in_ready_o", 32'(in_ready_o), 0);
    check("evt_miss_o", 32'(evt_miss_o), 1);
    wait_ready();
    check("in_data_o", in_data_o, expected_word(32'h0000_0424));
    end_fetch();
    drain();
  endtask

  task automatic round_robin_evicts();
    $display("Test: round-robin eviction");
    for (int i = 0; i < 5; i++) begin
      fetch_line(32'h0000_8000 + 32'(20 * i));
    end
    start_fetch(32'h0000_8050);
    check("in_ready_o", 32'(in_ready_o), 1);
    end_fetch();
    // Fifth fill reused the first line's slot
    start_fetch(32'h0000_8000);
    check("in_ready_o", 32'(in_ready_o), 0);
    check("evt_miss_o", 32'(evt_miss_o), 1);
    wait_ready();
    end_fetch();
    drain();
  endtask

  task automatic next_line_prefetch();
    $display("Test: next-line prefetch");
    @(posedge clk_i);
    enable_prefetch_i <= 1'b1;
    prefetch_after_hit(32'h0000_3008, line_of(32'h0000_3008) + 32'd16);
    start_fetch(32'h0000_3014);
    check("in_ready_o", 32'(in_ready_o), 1);
    check("in_data_o", in_data_o, expected_word(32'h0000_3014));
    end_fetch();
    drain();
  endtask

  task automatic branch_jump_prefetch();
    $display("Test: branch and jump prefetch");
    prefetch_after_hit(BEQ_ADDR, line_of(BEQ_ADDR - 32'd64));
    prefetch_after_hit(JAL_ADDR, line_of(JAL_ADDR + 32'd256));
  endtask

  task automatic back_pressure_holds();
    int n;
    n = 0;
    $display("Test: back-pressure");
    @(posedge clk_i);
    enable_prefetch_i <= 1'b0;
    mem_hold          <= 1'b1;
    start_fetch(32'h0000_5000);
    for (int i = 0; i < 5; i++) begin
      check("out_req_valid_o", 32'(out_req_valid_o), 1);
      check("out_req_addr_o", out_req_addr_o, 32'h0000_5000);
      check("out_req_is_prefetch_o", 32'(out_req_is_prefetch_o), 0);
      @(negedge clk_i);
    end
    @(posedge clk_i);
    mem_hold <= 1'b0;
    @(negedge clk_i);
    while (out_req_valid_o && n < WAIT_LIMIT) begin
      @(negedge clk_i);
      n++;
    end
    if (out_req_valid_o) begin
      other_errors++;
      $display("Refill request never accepted after ready was released");
    end
    // A new miss while the refill is pending must stay quiet
    @(posedge clk_i);
    in_addr_i <= 32'h0000_6004;
    repeat (2) begin
      @(negedge clk_i);
      check("out_req_valid_o", 32'(out_req_valid_o), 0);
      check("in_ready_o", 32'(in_ready_o), 0);
    end
    wait_ready();
    check("in_data_o", in_data_o, expected_word(32'h0000_6004));
    end_fetch();
    drain();
    check("overlapping requests", mem_overlaps, 0);
  endtask

  // --------------------------------------------------------------------------
  // Main sequence and timeout
  // --------------------------------------------------------------------------
  initial begin
    clk_i             = 1'b0;
    rst_ni            = 1'b0;
    flush_i           = 1'b0;
    enable_prefetch_i = 1'b0;
    in_valid_i        = 1'b0;
    in_addr_i         = '0;
    mem_hold          = 1'b0;
    check_count       = 0;
    check_errors      = 0;
    other_errors      = 0;
    repeat (RESET_CYCLES) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(negedge clk_i);
    check("in_ready_o", 32'(in_ready_o), 0);
    check("out_req_valid_o", 32'(out_req_valid_o), 0);
    check("evt_hit_o", 32'(evt_hit_o), 0);
    check("evt_miss_o", 32'(evt_miss_o), 0);
    check("evt_prefetch_o", 32'(evt_prefetch_o), 0);
    miss_then_hit();
    flush_invalidates();
    round_robin_evicts();
    next_line_prefetch();
    branch_jump_prefetch();
    back_pressure_holds();
    $display("Summary: %0d checks, %0d check failures, %0d other failures",
             check_count, check_errors, other_errors);
    if (check_errors == 0 && other_errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < MAX_CYCLES) begin
      @(posedge clk_i);
      cycle_cnt++;
    end
    $display("Timeout after %0d cycles, run stopped", MAX_CYCLES);
    $display("*** FAILED ***");
    $finish;
  end

endmodule

// ==== dv/l0_icache_tb_mem.sv ====
/*
 * Refill memory model for the L0 cache testbench
 * Random ready, one line returned a fixed delay after each accepted request
 */

`timescale 1ns/1ns

module l0_icache_tb_mem #(
  parameter int          SEED     = 1,
  parameter logic [31:0] BEQ_ADDR = '0,
  parameter logic [31:0] BEQ_WORD = '0,
  parameter logic [31:0] JAL_ADDR = '0,
  parameter logic [31:0] JAL_WORD = '0
) (
  input  logic         clk_i,
  input  logic         rst_ni,
  input  logic         hold_i,
  input  logic         req_valid_i,
  input  logic [31:0]  req_addr_i,
  output logic         req_ready_o,
  output logic         rsp_valid_o,
  output logic [127:0] rsp_data_o,
  output logic         busy_o,
  output int           overlaps_o
);

  localparam int DELAY = 3;

  integer       seed       = SEED;
  int           rnd;
  logic         ready_q    = 1'b0;
  logic         rsp_q      = 1'b0;
  logic         busy_q     = 1'b0;
  logic [127:0] data_q     = '0;
  logic [31:0]  addr_q     = '0;
  int           count_q    = 0;
  int           overlaps_q = 0;

  function automatic logic [31:0] word_at(input logic [31:0] a);
    logic [31:0] w;
    // ADDI opcode with the address folded into the upper bits
    w = {a[31:7] ^ a[24:0], 7'b0010011};
    if (a == BEQ_ADDR) begin
      w = BEQ_WORD;
    end else if (a == JAL_ADDR) begin
      w = JAL_WORD;
    end
    return w;
  endfunction

  function automatic logic [127:0] line_at(input logic [31:0] base);
    logic [127:0] line;
    for (int i = 0; i < 4; i++) begin
      line[32*i +: 32] = word_at(base + 32'(4 * i));
    end
    return line;
  endfunction

  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ready_q    <= 1'b0;
      rsp_q      <= 1'b0;
      busy_q     <= 1'b0;
      count_q    <= 0;
      overlaps_q <= 0;
    end else begin
      rnd     = $random(seed);
      ready_q <= !hold_i && rnd[0];
      rsp_q   <= 1'b0;
      if (req_valid_i && ready_q) begin
        // A second request before the response is a protocol error
        if (busy_q) begin
          overlaps_q <= overlaps_q + 1;
        end
        busy_q  <= 1'b1;
        addr_q  <= req_addr_i;
        count_q <= DELAY;
      end else if (busy_q) begin
        count_q <= count_q - 1;
        if (count_q == 1) begin
          busy_q <= 1'b0;
          rsp_q  <= 1'b1;
          data_q <= line_at(addr_q);
        end
      end
    end
  end

  assign req_ready_o = ready_q;
  assign rsp_valid_o = rsp_q;
  assign rsp_data_o  = data_q;
  assign busy_o      = busy_q | rsp_q;
  assign overlaps_o  = overlaps_q;

endmodule

// ==== design/l0_icache.sv ====
/*
 * L0 instruction cache top
 * Single fetch port, fully associative line store with optional prefetch
 */

`timescale 1ns/1ns

`include "l0_cfg.svh"

module l0_icache import l0_icache_pkg::*; (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    flush_i,
  input  logic                    enable_prefetch_i,
  input  logic                    in_valid_i,
  input  logic [`L0_ADDR_W-1:0]   in_addr_i,
  output logic [`L0_FETCH_W-1:0]  in_data_o,
  output logic                    in_ready_o,
  output logic [`L0_ADDR_W-1:0]   out_req_addr_o,
  output logic                    out_req_valid_o,
  output logic                    out_req_is_prefetch_o,
  input  logic                    out_req_ready_i,
  input  logic                    out_rsp_valid_i,
  input  logic [`L0_LINE_W-1:0]   out_rsp_data_i,
  output logic                    evt_hit_o,
  output logic                    evt_miss_o,
  output logic                    evt_prefetch_o
);

  word_t [L0_PKTS_PER_LINE-1:0] line_words;

  l0_lookup_if lookup ();
  l0_evict_if  evict ();

  l0_line_store i_line_store (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .flush_i      (flush_i),
    .fetch_addr_i (in_addr_i),
    .lookup       (lookup),
    .evict        (evict)
  );

  l0_branch_predecode i_branch_predecode (
    .fetch_addr_i (in_addr_i),
    .lookup       (lookup)
  );

  l0_refill_ctrl i_refill_ctrl (
    .clk_i                 (clk_i),
    .rst_ni                (rst_ni),
    .in_valid_i            (in_valid_i),
    .enable_prefetch_i     (enable_prefetch_i),
    .fetch_addr_i          (in_addr_i),
    .lookup                (lookup),
    .evict                 (evict),
    .out_req_ready_i       (out_req_ready_i),
    .out_rsp_valid_i       (out_rsp_valid_i),
    .out_rsp_data_i        (out_rsp_data_i),
    .out_req_addr_o        (out_req_addr_o),
    .out_req_valid_o       (out_req_valid_o),
    .out_req_is_prefetch_o (out_req_is_prefetch_o),
    .evt_hit_o             (evt_hit_o),
    .evt_miss_o            (evt_miss_o),
    .evt_prefetch_o        (evt_prefetch_o)
  );

  // Word select out of the hit line
  assign line_words = lookup.hit_line;
  assign in_ready_o = lookup.hit;
  assign in_data_o  = line_words[in_addr_i[`L0_LINE_ALIGN-1:`L0_FETCH_ALIGN]];

endmodule

// ==== design/l0_refill_ctrl.sv ====
/*
 * L0 refill controller
 * Miss detection, single pending refill, prefetch latch and request arbiter
 */

`timescale 1ns/1ns

`include "l0_cfg.svh"

module l0_refill_ctrl import l0_icache_pkg::*; (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              in_valid_i,
  input  logic              enable_prefetch_i,
  input  addr_t             fetch_addr_i,
  l0_lookup_if.ctrl         lookup,
  l0_evict_if.ctrl          evict,
  input  logic              out_req_ready_i,
  input  logic              out_rsp_valid_i,
  input  line_t             out_rsp_data_i,
  output addr_t             out_req_addr_o,
  output logic              out_req_valid_o,
  output logic              out_req_is_prefetch_o,
  output logic              evt_hit_o,
  output logic              evt_miss_o,
  output logic              evt_prefetch_o
);

  logic  miss;
  logic  miss_q;
  logic  pf_valid;
  logic  latch_pf;
  logic  pf_req_valid_q;
  addr_t pf_req_addr_q;
  logic  pending_q;
  logic  refill_ready;
  logic  pf_ready;
  addr_t refill_addr;

  assign miss        = in_valid_i & ~lookup.hit & ~pending_q;
  assign refill_addr = {fetch_addr_i[`L0_ADDR_W-1:`L0_LINE_ALIGN], {`L0_LINE_ALIGN{1'b0}}};

  // Prefetch only on a hit, when the target is absent and the port is idle
  assign pf_valid = enable_prefetch_i & in_valid_i & lookup.hit &
                    ~lookup.cand_present & ~pending_q;
  assign latch_pf = pf_valid & ~pf_req_valid_q;

  // --------------------------------------------------------------------------
  // Eviction and fill
  // --------------------------------------------------------------------------
  assign evict.evict      = (miss & ~miss_q) | latch_pf;
  assign evict.evict_tag  = latch_pf ? lookup.cand_addr[`L0_ADDR_W-1:`L0_LINE_ALIGN]
                                     : fetch_addr_i[`L0_ADDR_W-1:`L0_LINE_ALIGN];
  assign evict.fill_valid = out_rsp_valid_i & pending_q;
  assign evict.fill_data  = out_rsp_data_i;

  // --------------------------------------------------------------------------
  // Request arbiter, refill first
  // --------------------------------------------------------------------------
  always_comb begin
    out_req_valid_o       = pf_req_valid_q;
    out_req_addr_o        = pf_req_addr_q;
    out_req_is_prefetch_o = 1'b1;
    pf_ready              = out_req_ready_i;
    refill_ready          = 1'b0;
    if (miss) begin
      out_req_valid_o       = 1'b1;
      out_req_addr_o        = refill_addr;
      out_req_is_prefetch_o = 1'b0;
      pf_ready              = 1'b0;
      refill_ready          = out_req_ready_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      miss_q         <= 1'b0;
      pending_q      <= 1'b0;
      pf_req_valid_q <= 1'b0;
    end else begin
      miss_q <= miss;
      if (pending_q) begin
        if (out_rsp_valid_i) begin
          pending_q <= 1'b0;
        end
      end else if ((miss && refill_ready) || latch_pf) begin
        pending_q <= 1'b1;
      end
      if (latch_pf) begin
        pf_req_valid_q <= 1'b1;
      end else if (pf_ready) begin
        pf_req_valid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (latch_pf) begin
      pf_req_addr_q <= lookup.cand_addr;
    end
  end

  // Event pulses
  assign evt_hit_o      = in_valid_i & lookup.hit;
  assign evt_miss_o     = miss;
  assign evt_prefetch_o = latch_pf;

endmodule

// ==== design/l0_branch_predecode.sv ====
/*
 * L0 branch predecoder
 * Finds the first taken branch or JAL in the hit line and forms the
 * line-aligned prefetch candidate, falling back to the next line
 */

`timescale 1ns/1ns

`include "l0_cfg.svh"

module l0_branch_predecode import l0_icache_pkg::*; (
  input  addr_t              fetch_addr_i,
  l0_lookup_if.decode        lookup
);

  localparam int unsigned WORD_IDX_W = `L0_LINE_ALIGN - `L0_FETCH_ALIGN;

  instr_u [L0_PKTS_PER_LINE-1:0] pkts;
  logic   [L0_PKTS_PER_LINE-1:0] is_branch_taken;
  logic   [L0_PKTS_PER_LINE-1:0] is_jal;
  logic   [L0_PKTS_PER_LINE-1:0] mask;
  logic   [WORD_IDX_W-1:0]       taken_idx;
  logic                          found;
  instr_u                        taken_ins;
  addr_t                         sb_imm;
  addr_t                         uj_imm;
  addr_t                         base_addr;
  addr_t                         offset;
  addr_t                         target;

  assign pkts = lookup.hit_line;

  // Only words at or after the fetch word are of interest
  assign mask = '1 << fetch_addr_i[`L0_LINE_ALIGN-1:`L0_FETCH_ALIGN];

  // Static prediction: backward branches taken, forward not
  always_comb begin
    for (int i = 0; i < L0_PKTS_PER_LINE; i++) begin
      // funct3 010 and 011 are not branches
      is_branch_taken[i] = (pkts[i].b_fmt.opcode == OPC_BRANCH) &&
                           (pkts[i].b_fmt.funct3[2:1] != 2'b01) &&
                           pkts[i].b_fmt.imm12;
      is_jal[i]          = (pkts[i].j_fmt.opcode == OPC_JAL);
    end
  end

  // Lowest qualifying word wins
  always_comb begin : first_taken
    found     = 1'b0;
    taken_idx = '0;
    for (int i = 0; i < L0_PKTS_PER_LINE; i++) begin
      if (!found && mask[i] && (is_branch_taken[i] || is_jal[i])) begin
        found     = 1'b1;
        taken_idx = WORD_IDX_W'(i);
      end
    end
  end

  assign taken_ins = pkts[taken_idx];

  assign sb_imm = {{20{taken_ins.b_fmt.imm12}}, taken_ins.b_fmt.imm11,
                   taken_ins.b_fmt.imm10_5, taken_ins.b_fmt.imm4_1, 1'b0};
  assign uj_imm = {{12{taken_ins.j_fmt.imm20}}, taken_ins.j_fmt.imm19_12,
                   taken_ins.j_fmt.imm11, taken_ins.j_fmt.imm10_1, 1'b0};

  // --------------------------------------------------------------------------
  // Candidate address
  // --------------------------------------------------------------------------
  always_comb begin
    // Next line by default
    base_addr = fetch_addr_i;
    offset    = addr_t'(1) << `L0_LINE_ALIGN;
    if (found) begin
      base_addr = {fetch_addr_i[`L0_ADDR_W-1:`L0_LINE_ALIGN], taken_idx,
                   {`L0_FETCH_ALIGN{1'b0}}};
      offset    = is_jal[taken_idx] ? uj_imm : sb_imm;
    end
  end

  assign target           = base_addr + offset;
  assign lookup.cand_addr = {target[`L0_ADDR_W-1:`L0_LINE_ALIGN], {`L0_LINE_ALIGN{1'b0}}};

endmodule

// ==== design/l0_line_store.sv ====
/*
 * L0 line store
 * Fully associative tag/data arrays with parallel compare for the fetch
 * and the prefetch candidate, round-robin victim choice and fill target
 */

`timescale 1ns/1ns

`include "l0_cfg.svh"

module l0_line_store import l0_icache_pkg::*; (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              flush_i,
  input  addr_t             fetch_addr_i,
  l0_lookup_if.store        lookup,
  l0_evict_if.store         evict
);

  tag_t  [`L0_LINE_COUNT-1:0] tag_q;
  line_t [`L0_LINE_COUNT-1:0] data_q;
  way_strb_t                  valid_q;
  // One-hot line waiting for its refill
  way_strb_t                  target_q;
  way_idx_t                   rr_q;
  way_idx_t                   rr_d;

  way_strb_t hit_strb;
  way_strb_t cand_strb;
  way_strb_t victim_strb;
  tag_t      fetch_tag;
  tag_t      cand_tag;
  line_t     hit_data;

  assign fetch_tag = fetch_addr_i[`L0_ADDR_W-1:`L0_LINE_ALIGN];
  assign cand_tag  = lookup.cand_addr[`L0_ADDR_W-1:`L0_LINE_ALIGN];

  // --------------------------------------------------------------------------
  // Tag compare
  // --------------------------------------------------------------------------
  always_comb begin
    for (int i = 0; i < `L0_LINE_COUNT; i++) begin
      hit_strb[i]  = valid_q[i] & (tag_q[i] == fetch_tag);
      cand_strb[i] = valid_q[i] & (tag_q[i] == cand_tag);
    end
  end

  // AND-OR mux, zero when nothing hits
  always_comb begin
    hit_data = '0;
    for (int i = 0; i < `L0_LINE_COUNT; i++) begin
      hit_data |= {`L0_LINE_W{hit_strb[i]}} & data_q[i];
    end
  end

  assign lookup.hit          = |hit_strb;
  assign lookup.hit_line     = hit_data;
  assign lookup.cand_present = |cand_strb;

  // --------------------------------------------------------------------------
  // Victim selection
  // --------------------------------------------------------------------------
  always_comb begin : victim_sel
    victim_strb = way_strb_t'(1) << rr_q;
    rr_d        = rr_q;
    if (evict.evict) begin
      rr_d = rr_q + way_idx_t'(1);
      // Never throw out the line the fetch is using right now
      if (victim_strb == hit_strb) begin
        victim_strb = way_strb_t'(1) << rr_d;
        rr_d        = rr_q + way_idx_t'(2);
      end
    end
  end

  // --------------------------------------------------------------------------
  // Valid bits and pointer
  // --------------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= '0;
      rr_q    <= '0;
    end else begin
      rr_q <= rr_d;
      for (int i = 0; i < `L0_LINE_COUNT; i++) begin
        if (evict.evict && victim_strb[i]) begin
          valid_q[i] <= 1'b0;
        end else if (evict.fill_valid && target_q[i]) begin
          valid_q[i] <= 1'b1;
        end
      end
      // Flush wins over a fill in the same cycle
      if (flush_i) begin
        valid_q <= '0;
      end
    end
  end

  // --------------------------------------------------------------------------
  // Tag, data and fill target
  // --------------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (evict.evict) begin
      target_q <= victim_strb;
    end
    for (int i = 0; i < `L0_LINE_COUNT; i++) begin
      if (evict.evict && victim_strb[i]) begin
        tag_q[i] <= evict.evict_tag;
      end
      if (evict.fill_valid && target_q[i]) begin
        data_q[i] <= evict.fill_data;
      end
    end
  end

endmodule

// ==== design/l0_evict_if.sv ====
/*
 * L0 evict interface
 * Victim claim and refill commands from the controller to the line store
 */

`timescale 1ns/1ns

interface l0_evict_if import l0_icache_pkg::*; ();

  // Claim a victim and tag it for the next fill
  logic  evict;
  tag_t  evict_tag;

  // Refill data for the claimed line
  logic  fill_valid;
  line_t fill_data;

  modport ctrl (
    output evict, evict_tag, fill_valid, fill_data
  );

  modport store (
    input  evict, evict_tag, fill_valid, fill_data
  );

endinterface

// ==== design/l0_lookup_if.sv ====
/*
 * L0 lookup interface
 * Hit result from the line store and prefetch candidate from the predecoder
 */

`timescale 1ns/1ns

interface l0_lookup_if import l0_icache_pkg::*; ();

  // Fetch lookup
  logic  hit;
  line_t hit_line;

  // Prefetch candidate and its presence in the store
  addr_t cand_addr;
  logic  cand_present;

  modport store (
    output hit, hit_line, cand_present,
    input  cand_addr
  );

  modport decode (
    input  hit_line,
    output cand_addr
  );

  modport ctrl (
    input  hit, cand_present, cand_addr
  );

endinterface

// ==== design/l0_icache_pkg.sv ====
/*
 * L0 instruction cache package
 * Common types, RISC-V opcodes and the instruction word decode union
 */

`include "l0_cfg.svh"

package l0_icache_pkg;

  // --------------------------------------------------------------------------
  // Basic types
  // --------------------------------------------------------------------------
  typedef logic [`L0_ADDR_W-1:0]              addr_t;
  typedef logic [`L0_TAG_W-1:0]               tag_t;
  typedef logic [`L0_LINE_W-1:0]              line_t;
  typedef logic [`L0_FETCH_W-1:0]             word_t;
  typedef logic [`L0_LINE_COUNT-1:0]          way_strb_t;
  typedef logic [$clog2(`L0_LINE_COUNT)-1:0]  way_idx_t;

  // Instruction words per line
  localparam int unsigned L0_PKTS_PER_LINE = `L0_LINE_W / `L0_FETCH_W;

  // --------------------------------------------------------------------------
  // Opcodes seen by the predecoder
  // --------------------------------------------------------------------------
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;

  // --------------------------------------------------------------------------
  // Instruction layouts
  // --------------------------------------------------------------------------
  // Conditional branch, SB-type immediate
  typedef struct packed {
    logic       imm12;
    logic [5:0] imm10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm4_1;
    logic       imm11;
    logic [6:0] opcode;
  } b_fmt_t;

  // Jump and link, UJ-type immediate
  typedef struct packed {
    logic       imm20;
    logic [9:0] imm10_1;
    logic       imm11;
    logic [7:0] imm19_12;
    logic [4:0] rd;
    logic [6:0] opcode;
  } j_fmt_t;

  // Same 32-bit word seen as either layout, opcode shared at the bottom
  typedef union packed {
    b_fmt_t b_fmt;
    j_fmt_t j_fmt;
  } instr_u;

endpackage

// ==== include/l0_cfg.svh ====
/*
 * L0 instruction cache sizing
 * Address, fetch word, line and store dimensions
 */

`ifndef L0_CFG_SVH
`define L0_CFG_SVH

// Fetch side
`define L0_ADDR_W       32
`define L0_FETCH_W      32
`define L0_FETCH_ALIGN  2

// Line geometry
`define L0_LINE_W       128
`define L0_LINE_ALIGN   4

// Fully associative store
`define L0_LINE_COUNT   4

// Tag is everything above the line offset
`define L0_TAG_W        (`L0_ADDR_W - `L0_LINE_ALIGN)

`endif
